//--- rtl/flash_ctrl_top.sv
`timescale 1ns/1ps

module flash_ctrl_top #(
	parameter int LINE_WORDS = 4,
	parameter int NUM_LINES  = 8,
	parameter int SCK_DIV    = 2
) (
	input  logic                              wb_clk_i,
	input  logic                              arst_n_i,
	input  logic                              wb_cyc_i,
	input  logic                              wb_stb_i,
	input  logic                              wb_we_i,
	input  logic [flash_pkg::FLASH_ADDR_W-1:0] wb_adr_i,
	output logic                              wb_ack_o,
	output logic                              wb_error_o,
	output logic                              wb_stall_o,
	output logic [flash_pkg::DATA_W-1:0]      wb_data_o,
	output logic                              flash_csb_o,
	output logic                              flash_sck_o,
	output logic                              flash_io0_o,
	output logic                              flash_io0_oe_o,
	input  logic                              flash_io1_i
);
	import flash_pkg::*;

	// port to cache
	logic cache_req_valid;
	cache_req_t cache_req;
	logic cache_rsp_valid;
	cache_rsp_t cache_rsp;

	// cache to reader
	logic fill_req_valid;
	fill_req_t fill_req;
	logic fill_word_valid;
	fill_word_t fill_word;

	// bus side, one request at a time
	wb_flash_port i_port (
		.wb_clk_i          (wb_clk_i),
		.arst_n_i          (arst_n_i),
		.wb_cyc_i          (wb_cyc_i),
		.wb_stb_i          (wb_stb_i),
		.wb_we_i           (wb_we_i),
		.wb_adr_i          (wb_adr_i),
		.wb_ack_o          (wb_ack_o),
		.wb_error_o        (wb_error_o),
		.wb_stall_o        (wb_stall_o),
		.wb_data_o         (wb_data_o),
		.cache_req_valid_o (cache_req_valid),
		.cache_req_o       (cache_req),
		.cache_rsp_valid_i (cache_rsp_valid),
		.cache_rsp_i       (cache_rsp)
	);

	// direct mapped lines
	flash_line_cache #(
		.LINE_WORDS (LINE_WORDS),
		.NUM_LINES  (NUM_LINES)
	) i_cache (
		.wb_clk_i          (wb_clk_i),
		.arst_n_i          (arst_n_i),
		.cache_req_valid_i (cache_req_valid),
		.cache_req_i       (cache_req),
		.cache_rsp_valid_o (cache_rsp_valid),
		.cache_rsp_o       (cache_rsp),
		.fill_req_valid_o  (fill_req_valid),
		.fill_req_o        (fill_req),
		.fill_word_valid_i (fill_word_valid),
		.fill_word_i       (fill_word)
	);

	// serial flash, single bit read
	spi_flash_reader #(
		.LINE_WORDS (LINE_WORDS),
		.SCK_DIV    (SCK_DIV)
	) i_reader (
		.wb_clk_i          (wb_clk_i),
		.arst_n_i          (arst_n_i),
		.fill_req_valid_i  (fill_req_valid),
		.fill_req_i        (fill_req),
		.fill_word_valid_o (fill_word_valid),
		.fill_word_o       (fill_word),
		.flash_csb_o       (flash_csb_o),
		.flash_sck_o       (flash_sck_o),
		.flash_io0_o       (flash_io0_o),
		.flash_io0_oe_o    (flash_io0_oe_o),
		.flash_io1_i       (flash_io1_i)
	);

endmodule

//--- rtl/flash_line_cache.sv
`timescale 1ns/1ps

module flash_line_cache #(
	parameter int LINE_WORDS = 4,
	parameter int NUM_LINES  = 8
) (
	input  logic                  wb_clk_i,
	input  logic                  arst_n_i,
	input  logic                  cache_req_valid_i,
	input  flash_pkg::cache_req_t cache_req_i,
	output logic                  cache_rsp_valid_o,
	output flash_pkg::cache_rsp_t cache_rsp_o,
	output logic                  fill_req_valid_o,
	output flash_pkg::fill_req_t  fill_req_o,
	input  logic                  fill_word_valid_i,
	input  flash_pkg::fill_word_t fill_word_i
);
	import flash_pkg::*;

	// word address = tag | set | offset
	// both counts are powers of two, at least two
	localparam int OFF_W = $clog2(LINE_WORDS);
	localparam int SET_W = $clog2(NUM_LINES);
	localparam int TAG_W = WORD_ADDR_W - SET_W - OFF_W;

	cache_state_e state_q;
	cache_req_t req_q;

	// line storage, one entry per word
	logic [DATA_W-1:0] data_mem [NUM_LINES*LINE_WORDS];
	logic [TAG_W-1:0] tag_mem [NUM_LINES];
	logic [NUM_LINES-1:0] valid_q;

	logic [OFF_W-1:0] off;
	logic [SET_W-1:0] set;
	logic [TAG_W-1:0] tag;
	logic hit;
	logic fill_last;

	// fields of the held request
	assign off = req_q.word_addr[OFF_W-1:0];
	assign set = req_q.word_addr[OFF_W +: SET_W];
	assign tag = req_q.word_addr[WORD_ADDR_W-1 -: TAG_W];

	// tag compare on the registered request
	assign hit = valid_q[set] && (tag_mem[set] == tag);

	assign fill_last = (state_q == CACHE_FILL) && fill_word_valid_i && fill_word_i.last;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= CACHE_IDLE;
			valid_q <= '0;
		end else begin
			case (state_q)
				CACHE_IDLE: begin
					if (cache_req_valid_i) begin
						state_q <= CACHE_LOOKUP;
					end
				end
				CACHE_LOOKUP: begin
					if (hit) begin
						state_q <= CACHE_IDLE;
					end else begin
						// old line is overwritten word by word
						valid_q[set] <= 1'b0;
						state_q      <= CACHE_FILL;
					end
				end
				CACHE_FILL: begin
					if (fill_last) begin
						valid_q[set] <= 1'b1;
						state_q      <= CACHE_RESPOND;
					end
				end
				CACHE_RESPOND: begin
					state_q <= CACHE_IDLE;
				end
				default: state_q <= CACHE_IDLE;
			endcase
		end
	end

	// request hold, line words and tags
	always_ff @(posedge wb_clk_i) begin
		if (state_q == CACHE_IDLE && cache_req_valid_i) begin
			req_q <= cache_req_i;
		end
		if (state_q == CACHE_FILL && fill_word_valid_i) begin
			data_mem[{set, fill_word_i.idx[OFF_W-1:0]}] <= fill_word_i.data;
		end
		// tag becomes valid with the last word
		if (fill_last) begin
			tag_mem[set] <= tag;
		end
	end

	// hit answers during lookup, miss after the fill
	assign cache_rsp_valid_o = ((state_q == CACHE_LOOKUP) && hit) ||
		(state_q == CACHE_RESPOND);
	assign cache_rsp_o.data = data_mem[{set, off}];

	// single pulse, lookup lasts one cycle
	assign fill_req_valid_o = (state_q == CACHE_LOOKUP) && !hit;
	// line aligned word address
	assign fill_req_o.line_addr = {req_q.word_addr[WORD_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

endmodule

//--- rtl/flash_pkg.sv
package flash_pkg;

	// flash byte address as sent after the command
	localparam int FLASH_ADDR_W = 24;
	// bus word
	localparam int DATA_W = 32;
	// word address, byte address without the two low bits
	localparam int WORD_ADDR_W = 22;
	// word-in-line index, room for lines of up to 16 words
	localparam int LINE_IDX_W = 4;

	// serial flash opcodes
	typedef enum logic [7:0] {
		CMD_READ = 8'h03
	} spi_cmd_e;

	// bus front end
	typedef enum logic {
		PORT_IDLE,
		PORT_WAIT
	} port_state_e;

	// line cache
	typedef enum logic [1:0] {
		CACHE_IDLE,
		CACHE_LOOKUP,
		CACHE_FILL,
		CACHE_RESPOND
	} cache_state_e;

	// serial reader
	typedef enum logic [2:0] {
		SPI_IDLE,
		SPI_CMD,
		SPI_ADDR,
		SPI_DATA,
		SPI_END
	} spi_state_e;

	// port to cache
	typedef struct packed {
		logic [WORD_ADDR_W-1:0] word_addr;
	} cache_req_t;

	// cache to port
	typedef struct packed {
		logic [DATA_W-1:0] data;
	} cache_rsp_t;

	// cache to reader, word address of the first word in the line
	typedef struct packed {
		logic [WORD_ADDR_W-1:0] line_addr;
	} fill_req_t;

	// reader to cache, one per line word
	typedef struct packed {
		logic [LINE_IDX_W-1:0] idx;
		logic                  last;
		logic [DATA_W-1:0]     data;
	} fill_word_t;

endpackage

//--- rtl/spi_flash_reader.sv
`timescale 1ns/1ps

module spi_flash_reader #(
	parameter int LINE_WORDS = 4,
	parameter int SCK_DIV    = 2
) (
	input  logic                  wb_clk_i,
	input  logic                  arst_n_i,
	input  logic                  fill_req_valid_i,
	input  flash_pkg::fill_req_t  fill_req_i,
	output logic                  fill_word_valid_o,
	output flash_pkg::fill_word_t fill_word_o,
	output logic                  flash_csb_o,
	output logic                  flash_sck_o,
	output logic                  flash_io0_o,
	output logic                  flash_io0_oe_o,
	input  logic                  flash_io1_i
);
	import flash_pkg::*;

	// divider needs at least one bit
	localparam int DIV_W = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;

	spi_state_e state_q;
	logic [DIV_W-1:0] div_q;
	logic sck_q;
	logic csb_q;
	logic oe_q;
	logic [4:0] bit_q;
	logic [LINE_IDX_W-1:0] word_q;
	logic [31:0] out_sh;
	logic [DATA_W-1:0] in_sh;
	logic word_valid_q;

	logic active;
	logic tick;
	logic sck_rise;
	logic sck_fall;
	logic sample;
	logic word_done;
	logic line_done;

	// first byte in lands in bits 7:0
	function automatic logic [DATA_W-1:0] byte_swap(input logic [DATA_W-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign active = (state_q == SPI_CMD) || (state_q == SPI_ADDR) || (state_q == SPI_DATA);
	// end of a half period
	assign tick = (div_q == DIV_W'(SCK_DIV - 1));
	assign sck_rise = active && tick && !sck_q;
	assign sck_fall = active && tick && sck_q;
	// mode 0, io1 taken as sck goes high
	assign sample = sck_rise && (state_q == SPI_DATA);
	assign word_done = sample && (bit_q == 5'd31);
	assign line_done = word_done && (word_q == LINE_IDX_W'(LINE_WORDS - 1));

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q      <= SPI_IDLE;
			div_q        <= '0;
			sck_q        <= 1'b0;
			csb_q        <= 1'b1;
			oe_q         <= 1'b0;
			bit_q        <= '0;
			word_q       <= '0;
			out_sh       <= '0;
			word_valid_q <= 1'b0;
		end else begin
			word_valid_q <= word_done;
			// half period counter
			if (active) begin
				div_q <= tick ? '0 : div_q + 1'b1;
			end else begin
				div_q <= '0;
			end
			case (state_q)
				SPI_IDLE: begin
					if (fill_req_valid_i) begin
						csb_q   <= 1'b0;
						oe_q    <= 1'b1;
						bit_q   <= '0;
						word_q  <= '0;
						// opcode then byte address, msb first
						out_sh  <= {CMD_READ, fill_req_i.line_addr, 2'b00};
						state_q <= SPI_CMD;
					end
				end
				SPI_CMD, SPI_ADDR, SPI_DATA: begin
					if (sck_rise) begin
						sck_q <= 1'b1;
					end
					if (sck_fall) begin
						sck_q  <= 1'b0;
						// io0 moves after the falling edge
						out_sh <= {out_sh[30:0], 1'b0};
						if (state_q == SPI_CMD && bit_q == 5'd7) begin
							bit_q   <= '0;
							state_q <= SPI_ADDR;
						end else if (state_q == SPI_ADDR && bit_q == 5'd23) begin
							bit_q   <= '0;
							state_q <= SPI_DATA;
						end else begin
							// wraps to 0 between data words
							bit_q <= bit_q + 1'b1;
						end
					end
					if (word_done) begin
						word_q <= word_q + 1'b1;
					end
					if (line_done) begin
						state_q <= SPI_END;
					end
				end
				SPI_END: begin
					// deselect together with sck low
					sck_q   <= 1'b0;
					csb_q   <= 1'b1;
					oe_q    <= 1'b0;
					state_q <= SPI_IDLE;
				end
				default: state_q <= SPI_IDLE;
			endcase
		end
	end

	// read shift register and word out
	always_ff @(posedge wb_clk_i) begin
		if (sample) begin
			in_sh <= {in_sh[DATA_W-2:0], flash_io1_i};
		end
		if (word_done) begin
			fill_word_o.idx  <= word_q;
			fill_word_o.last <= line_done;
			fill_word_o.data <= byte_swap({in_sh[DATA_W-2:0], flash_io1_i});
		end
	end

	assign fill_word_valid_o = word_valid_q;
	assign flash_csb_o       = csb_q;
	assign flash_sck_o       = sck_q;
	assign flash_io0_o       = out_sh[31];
	assign flash_io0_oe_o    = oe_q;

endmodule

//--- rtl/wb_flash_port.sv
`timescale 1ns/1ps

module wb_flash_port (
	input  logic                              wb_clk_i,
	input  logic                              arst_n_i,
	input  logic                              wb_cyc_i,
	input  logic                              wb_stb_i,
	input  logic                              wb_we_i,
	input  logic [flash_pkg::FLASH_ADDR_W-1:0] wb_adr_i,
	output logic                              wb_ack_o,
	output logic                              wb_error_o,
	output logic                              wb_stall_o,
	output logic [flash_pkg::DATA_W-1:0]      wb_data_o,
	output logic                              cache_req_valid_o,
	output flash_pkg::cache_req_t             cache_req_o,
	input  logic                              cache_rsp_valid_i,
	input  flash_pkg::cache_rsp_t             cache_rsp_i
);
	import flash_pkg::*;

	port_state_e state_q;
	logic stall_q;
	logic ack_q;
	logic error_q;
	logic req_valid_q;
	logic accept;
	logic bad_req;

	// one request in flight, stall blocks the next one
	assign accept = wb_cyc_i && wb_stb_i && !stall_q;
	// read only, word aligned
	assign bad_req = wb_we_i || (wb_adr_i[1:0] != 2'b00);

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= PORT_IDLE;
			stall_q     <= 1'b0;
			ack_q       <= 1'b0;
			error_q     <= 1'b0;
			req_valid_q <= 1'b0;
		end else begin
			// pulses last one cycle
			ack_q       <= 1'b0;
			error_q     <= 1'b0;
			req_valid_q <= 1'b0;
			// stall drops after the response cycle
			if (ack_q || error_q) begin
				stall_q <= 1'b0;
			end
			case (state_q)
				PORT_IDLE: begin
					if (accept) begin
						stall_q <= 1'b1;
						if (bad_req) begin
							// answered here, cache never sees it
							error_q <= 1'b1;
						end else begin
							req_valid_q <= 1'b1;
							state_q     <= PORT_WAIT;
						end
					end
				end
				PORT_WAIT: begin
					if (cache_rsp_valid_i) begin
						ack_q   <= 1'b1;
						state_q <= PORT_IDLE;
					end
				end
				default: state_q <= PORT_IDLE;
			endcase
		end
	end

	// request address and read data
	always_ff @(posedge wb_clk_i) begin
		if (accept && !bad_req) begin
			cache_req_o.word_addr <= wb_adr_i[FLASH_ADDR_W-1:2];
		end
		if (state_q == PORT_WAIT && cache_rsp_valid_i) begin
			wb_data_o <= cache_rsp_i.data;
		end
	end

	assign wb_ack_o          = ack_q;
	assign wb_error_o        = error_q;
	assign wb_stall_o        = stall_q;
	assign cache_req_valid_o = req_valid_q;

endmodule

//--- sources.f
rtl/flash_pkg.sv
rtl/wb_flash_port.sv
rtl/flash_line_cache.sv
rtl/spi_flash_reader.sv
rtl/flash_ctrl_top.sv
tb/flash_ctrl_assert.sv
tb/spi_flash_model.sv
tb/flash_checker.sv
tb/tb_flash_ctrl.sv

//--- tb/flash_checker.sv
`timescale 1ns/1ps

module flash_checker #(
	parameter int LINE_WORDS = 4,
	parameter int NUM_LINES  = 8
) (
	input logic                               wb_clk_i,
	input logic                               arst_n_i,
	input logic                               wb_cyc_i,
	input logic                               wb_stb_i,
	input logic                               wb_we_i,
	input logic [flash_pkg::FLASH_ADDR_W-1:0] wb_adr_i,
	input logic                               wb_ack_i,
	input logic                               wb_error_i,
	input logic                               wb_stall_i,
	input logic [flash_pkg::DATA_W-1:0]       wb_data_i,
	input logic                               flash_csb_i,
	input logic                               flash_sck_i,
	input logic                               flash_io0_oe_i
);
	import flash_pkg::*;

	typedef enum logic [1:0] {
		KIND_ERROR,
		KIND_HIT,
		KIND_MISS
	} kind_e;

	// sck rises for command and address plus one line of data
	localparam int LINE_RISES = 32 + LINE_WORDS * 32;

	int err_cnt = 0;
	int acc_cnt = 0;
	int rsp_cnt = 0;
	longint cycle;
	longint acc_cycle;
	// mirrored tag store
	logic model_valid [NUM_LINES];
	int model_tag [NUM_LINES];
	logic pending;
	kind_e kind_q;
	logic [DATA_W-1:0] exp_data;
	logic [FLASH_ADDR_W-1:0] exp_adr;
	int bursts;
	int rises;
	logic csb_prev;
	logic sck_prev;

	function automatic logic [7:0] content_byte(input int unsigned a);
		int unsigned v;
		v = a * 7 + (a >> 8) + 32'h5a;
		return v[7:0];
	endfunction

	// lowest address in bits 7:0
	function automatic logic [DATA_W-1:0] expected_word(input int unsigned a);
		return {content_byte(a + 3), content_byte(a + 2),
			content_byte(a + 1), content_byte(a)};
	endfunction

	task automatic report_value(input string name, input longint got, input longint exp);
		err_cnt++;
		$display("error %s: got %h expected %h at address %h",
			name, got, exp, exp_adr);
	endtask

	always @(posedge wb_clk_i or negedge arst_n_i) begin
		int unsigned w;
		int set;
		int tag;
		longint lat;
		if (!arst_n_i) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				model_valid[i] = 1'b0;
			end
			pending = 1'b0;
			csb_prev = 1'b1;
			sck_prev = 1'b0;
			cycle = 0;
		end else begin
			cycle++;
			// flash pin activity since acceptance
			if (csb_prev && !flash_csb_i) begin
				bursts++;
				// only a predicted miss may start a transfer
				if (!pending || kind_q != KIND_MISS) begin
					err_cnt++;
					$display("flash transfer started without a predicted miss in flight");
				end
			end
			if (!sck_prev && flash_sck_i) begin
				rises++;
			end
			csb_prev = flash_csb_i;
			sck_prev = flash_sck_i;
			// io0 is driven exactly while the flash is selected
			if (flash_io0_oe_i !== !flash_csb_i) begin
				report_value("flash_io0_oe_o", flash_io0_oe_i, !flash_csb_i);
			end
			// stall follows the request in flight
			if (wb_stall_i !== pending) begin
				report_value("wb_stall_o", wb_stall_i, pending);
			end
			if (wb_ack_i || wb_error_i) begin
				lat = cycle - acc_cycle;
				rsp_cnt++;
				if (!pending) begin
					err_cnt++;
					$display("response seen without an accepted request");
				end else if (kind_q == KIND_ERROR) begin
					if (!wb_error_i || wb_ack_i) begin
						report_value("wb_error_o", wb_error_i, 1);
					end
					if (lat != 1) begin
						report_value("wb_error_o latency", lat, 1);
					end
					if (bursts != 0) begin
						report_value("flash_csb_o bursts", bursts, 0);
					end
				end else begin
					if (!wb_ack_i || wb_error_i) begin
						report_value("wb_ack_o", wb_ack_i, 1);
					end
					if (wb_data_i !== exp_data) begin
						report_value("wb_data_o", wb_data_i, exp_data);
					end
					if (kind_q == KIND_HIT) begin
						if (lat != 3) begin
							report_value("wb_ack_o latency", lat, 3);
						end
						if (bursts != 0) begin
							report_value("flash_csb_o bursts", bursts, 0);
						end
					end else begin
						// a fill can never be as fast as a hit
						if (lat <= 3) begin
							report_value("wb_ack_o miss latency", lat, 4);
						end
						if (bursts != 1) begin
							report_value("flash_csb_o bursts", bursts, 1);
						end
						if (rises != LINE_RISES) begin
							report_value("flash_sck_o rises", rises, LINE_RISES);
						end
					end
				end
				pending = 1'b0;
			end
			// predict the outcome of a new request
			if (wb_cyc_i && wb_stb_i && !wb_stall_i) begin
				w = wb_adr_i >> 2;
				set = (w / LINE_WORDS) % NUM_LINES;
				tag = w / (LINE_WORDS * NUM_LINES);
				exp_adr = wb_adr_i;
				if (wb_we_i || (wb_adr_i[1:0] != 2'b00)) begin
					kind_q = KIND_ERROR;
				end else begin
					kind_q = (model_valid[set] && model_tag[set] == tag) ?
						KIND_HIT : KIND_MISS;
					model_valid[set] = 1'b1;
					model_tag[set] = tag;
					exp_data = expected_word(wb_adr_i);
				end
				pending = 1'b1;
				acc_cycle = cycle;
				acc_cnt++;
				bursts = 0;
				rises = 0;
			end
		end
	end

endmodule

//--- tb/flash_ctrl_assert.sv
`timescale 1ns/1ps

module flash_ctrl_assert (
	input logic wb_clk_i,
	input logic arst_n_i,
	input logic wb_ack_i,
	input logic wb_error_i,
	input logic wb_stall_i,
	input logic flash_csb_i,
	input logic flash_sck_i
);

	// failures seen so far
	int fail_cnt = 0;

	// one response kind at a time
	a_ack_error_excl: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		!(wb_ack_i && wb_error_i))
	else begin
		fail_cnt++;
		$error("ack and error high in the same cycle");
	end

	// mode 0, sck idles low while deselected
	a_sck_idle: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		flash_csb_i |-> !flash_sck_i)
	else begin
		fail_cnt++;
		$error("sck high while csb is high");
	end

	// flash deselected right after reset
	a_csb_after_reset: assert property (@(posedge wb_clk_i)
		$rose(arst_n_i) |-> flash_csb_i)
	else begin
		fail_cnt++;
		$error("csb low in the cycle after reset");
	end

	// ack ends a stall that was already running
	a_ack_stalled: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		wb_ack_i |-> $past(wb_stall_i))
	else begin
		fail_cnt++;
		$error("ack without stall in the previous cycle");
	end

	// error rises together with stall
	a_error_stalled: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		wb_error_i |-> wb_stall_i)
	else begin
		fail_cnt++;
		$error("error without stall");
	end

endmodule

bind flash_ctrl_top flash_ctrl_assert i_assert (
	.wb_clk_i    (wb_clk_i),
	.arst_n_i    (arst_n_i),
	.wb_ack_i    (wb_ack_o),
	.wb_error_i  (wb_error_o),
	.wb_stall_i  (wb_stall_o),
	.flash_csb_i (flash_csb_o),
	.flash_sck_i (flash_sck_o)
);

//--- tb/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model #(
	parameter int LINE_WORDS = 4
) (
	input  logic flash_csb_i,
	input  logic flash_sck_i,
	input  logic flash_io0_i,
	input  logic flash_io0_oe_i,
	output logic flash_io1_o
);
	import flash_pkg::*;

	int err_cnt = 0;
	int rise_cnt = 0;
	int fall_cnt = 0;
	logic [31:0] header;
	logic [FLASH_ADDR_W-1:0] base;

	// computed flash content
	function automatic logic [7:0] content_byte(input int unsigned a);
		int unsigned v;
		v = a * 7 + (a >> 8) + 32'h5a;
		return v[7:0];
	endfunction

	initial flash_io1_o = 1'b0;

	// new transfer starts
	always @(negedge flash_csb_i) begin
		rise_cnt = 0;
		fall_cnt = 0;
		flash_io1_o = 1'b0;
	end

	// command then address, msb first
	always @(posedge flash_sck_i) begin
		if (flash_csb_i || !flash_io0_oe_i) begin
			err_cnt++;
			$display("flash model: sck rose while deselected or with io0 not driven");
		end
		if (rise_cnt < 32) begin
			header = {header[30:0], flash_io0_i};
			if (rise_cnt == 31) begin
				base = header[23:0];
				if (header[31:24] != CMD_READ) begin
					err_cnt++;
					$display("flash model: command %h is not the read command", header[31:24]);
				end
				if ((header[23:0] % (LINE_WORDS * 4)) != 0) begin
					err_cnt++;
					$display("flash model: address %h is not line aligned", header[23:0]);
				end
			end
		end
		rise_cnt++;
	end

	// data out after each falling edge
	always @(negedge flash_sck_i) begin
		int d;
		logic [7:0] b;
		fall_cnt++;
		if (fall_cnt >= 32) begin
			d = fall_cnt - 32;
			b = content_byte(base + d / 8);
			flash_io1_o = b[7 - d % 8];
		end
	end

endmodule

//--- tb/tb_flash_ctrl.sv
`timescale 1ns/1ps

module tb_flash_ctrl;
	import flash_pkg::*;

	localparam int LINE_WORDS = 4;
	localparam int NUM_LINES  = 8;
	localparam int SCK_DIV    = 2;
	localparam int NUM_REQS   = 400;
	// worst miss in cycles for the header plus one line
	localparam int MISS_CYCLES = (32 + LINE_WORDS * 32) * 2 * SCK_DIV + 10;
	localparam int TIMEOUT_NS  = NUM_REQS * MISS_CYCLES * 10 * 2;
	// window of 64 words is twice the cache size
	localparam logic [FLASH_ADDR_W-1:0] WINDOW_BASE = 24'h03_a000;

	logic clk;
	logic arst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [FLASH_ADDR_W-1:0] wb_adr;
	logic wb_ack;
	logic wb_error;
	logic wb_stall;
	logic [DATA_W-1:0] wb_data;
	logic flash_csb;
	logic flash_sck;
	logic flash_io0;
	logic flash_io0_oe;
	logic flash_io1;
	int total_errors;

	flash_ctrl_top #(
		.LINE_WORDS (LINE_WORDS),
		.NUM_LINES  (NUM_LINES),
		.SCK_DIV    (SCK_DIV)
	) i_dut (
		.wb_clk_i       (clk),
		.arst_n_i       (arst_n),
		.wb_cyc_i       (wb_cyc),
		.wb_stb_i       (wb_stb),
		.wb_we_i        (wb_we),
		.wb_adr_i       (wb_adr),
		.wb_ack_o       (wb_ack),
		.wb_error_o     (wb_error),
		.wb_stall_o     (wb_stall),
		.wb_data_o      (wb_data),
		.flash_csb_o    (flash_csb),
		.flash_sck_o    (flash_sck),
		.flash_io0_o    (flash_io0),
		.flash_io0_oe_o (flash_io0_oe),
		.flash_io1_i    (flash_io1)
	);

	spi_flash_model #(
		.LINE_WORDS (LINE_WORDS)
	) i_flash (
		.flash_csb_i    (flash_csb),
		.flash_sck_i    (flash_sck),
		.flash_io0_i    (flash_io0),
		.flash_io0_oe_i (flash_io0_oe),
		.flash_io1_o    (flash_io1)
	);

	flash_checker #(
		.LINE_WORDS (LINE_WORDS),
		.NUM_LINES  (NUM_LINES)
	) i_checker (
		.wb_clk_i       (clk),
		.arst_n_i       (arst_n),
		.wb_cyc_i       (wb_cyc),
		.wb_stb_i       (wb_stb),
		.wb_we_i        (wb_we),
		.wb_adr_i       (wb_adr),
		.wb_ack_i       (wb_ack),
		.wb_error_i     (wb_error),
		.wb_stall_i     (wb_stall),
		.wb_data_i      (wb_data),
		.flash_csb_i    (flash_csb),
		.flash_sck_i    (flash_sck),
		.flash_io0_oe_i (flash_io0_oe)
	);

	// 10 ns period
	always #5 clk = ~clk;

	// holds stb until taken and starts 1 ns after an edge
	task automatic issue_request(input logic we, input logic [FLASH_ADDR_W-1:0] adr);
		logic taken;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		taken = 1'b0;
		while (!taken) begin
			// stall is stable at mid cycle
			@(negedge clk);
			taken = !wb_stall;
			@(posedge clk);
			#1;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	initial begin
		int roll;
		int gap;
		logic we;
		logic [FLASH_ADDR_W-1:0] adr;
		clk = 1'b0;
		arst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		void'($urandom(32'h41c2_8b43));
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		for (int n = 0; n < NUM_REQS; n++) begin
			// 10 % writes and 5 % misaligned reads
			roll = $urandom % 100;
			adr = WINDOW_BASE + FLASH_ADDR_W'(($urandom % 64) * 4);
			we = (roll < 10);
			if (roll >= 10 && roll < 15) begin
				adr = adr | FLASH_ADDR_W'(1 + $urandom % 3);
			end
			issue_request(we, adr);
			gap = $urandom % 6;
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end
		// wait for the last response
		while (i_checker.rsp_cnt < NUM_REQS) @(posedge clk);
		repeat (5) @(posedge clk);
		total_errors = i_checker.err_cnt + i_flash.err_cnt + i_dut.i_assert.fail_cnt;
		$display("errors: checker %0d, flash model %0d, assertions %0d, requests %0d",
			i_checker.err_cnt, i_flash.err_cnt, i_dut.i_assert.fail_cnt, i_checker.acc_cnt);
		if (total_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// ends a hung run
	initial begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns with %0d of %0d requests answered",
			TIMEOUT_NS, i_checker.rsp_cnt, NUM_REQS);
		$display("TEST FAILED");
		$finish;
	end

endmodule
